// ==== vread.f ====
source/vread_pkg.sv
source/address_gen.sv
source/memory_writer.sv
source/buffer_ram_2p.sv
source/vread.sv
source/vread_top.sv
test/vread_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build vread_tb with Verilator and run it"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module vread_tb -f vread.f
	./obj_dir/Vvread_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "FAIL: see errors above" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== test/vread_tb.sv ====
`timescale 1ns/100ps

module vread_tb import vread_pkg::*; ;

   localparam logic [31:0] SEED = 32'h887b8732;
   localparam int SEL_W = $clog2(LANES);
   // five runs of a few hundred cycles at most with 3 wait states per word
   localparam int MAX_CYCLES = 4000;

   logic      clk;
   logic      rst;
   logic      run_i;
   logic      pingpong_i;
   read_cfg_t rcfg_i;
   gen_cfg_t  ocfg_i;
   wb_m2s_t   wb_o;
   wb_s2m_t   wb_i = '0;
   logic [ITEM_W-1:0] item_o;
   logic              item_valid_o;
   logic              done_o;

   // scoreboard state
   logic [BUS_DATA_W-1:0] model_mem [2**ADDR_W];
   bit                    written [2**ADDR_W];
   logic [ADDR_W-1:0]     read_addrs[$];
   logic [ITEM_W-1:0]     exp_items[$];
   logic [ITEM_W-1:0]     exp_item;
   logic [BUS_ADDR_W-1:0] cur_ext;
   int    cur_len = 0;
   int    ack_count = 0;
   int    item_idx = 0;
   bit    read_off = 1'b0;
   logic  tb_pp = 1'b0;
   string test_name = "reset";

   // bus slave state
   logic [31:0] rng = SEED;
   bit          pending = 1'b0;
   int          wait_left = 0;

   int burst_errs = 0;
   int item_errs = 0;
   int ctrl_errs = 0;
   int cycle_cnt = 0;

   vread_top #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W)
   ) UUT (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .pingpong_i  (pingpong_i),
      .rcfg_i      (rcfg_i),
      .ocfg_i      (ocfg_i),
      .wb_o        (wb_o),
      .wb_i        (wb_i),
      .item_o      (item_o),
      .item_valid_o(item_valid_o),
      .done_o      (done_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      return xorshift32(adr ^ SEED);
   endfunction

   function automatic gen_cfg_t make_gen(input int start, input int incr, input int per,
                                         input int duty, input int iter, input int shift,
                                         input int delay);
      gen_cfg_t c;
      c.start = ADDR_W'(start);
      c.incr  = ADDR_W'(incr);
      c.per   = PERIOD_W'(per);
      c.duty  = PERIOD_W'(duty);
      c.iter  = ADDR_W'(iter);
      c.shift = ADDR_W'(shift);
      c.delay = DELAY_W'(delay);
      return c;
   endfunction

   function automatic read_cfg_t make_read(input gen_cfg_t g, input logic [31:0] ext,
                                           input int len, input logic en);
      read_cfg_t r;
      r.gen      = g;
      r.ext_addr = ext;
      r.length   = LEN_W'(len);
      r.enabled  = en;
      return r;
   endfunction

   // word addresses the read side fills, in order
   task automatic plan_reads(input gen_cfg_t g, input logic [ADDR_W-1:0] base);
      logic [ADDR_W-1:0] a;
      int i;
      int p;
      a = base;
      for (i = 0; i < int'(g.iter); i++) begin
         for (p = 0; p < int'(g.per); p++) begin
            if (p < int'(g.duty)) begin
               read_addrs.push_back(a);
               a = a + g.incr;
            end
         end
         a = a + g.shift;
      end
   endtask

   // lane addresses to items through the buffer model
   task automatic plan_items(input gen_cfg_t oc, input logic pp, input logic half);
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] w;
      int i;
      int p;
      int lane;
      exp_items.delete();
      a = {half, oc.start[ADDR_W-2:0]};
      for (i = 0; i < int'(oc.iter); i++) begin
         for (p = 0; p < int'(oc.per); p++) begin
            if (p < int'(oc.duty)) begin
               w = ADDR_W'(a[ADDR_W-2:0] >> SEL_W);
               w[ADDR_W-1] = pp && a[ADDR_W-1];
               lane = int'(a[SEL_W-1:0]);
               if (!written[w]) begin
                  ctrl_errs++;
                  $display("%s reads buffer word %0d that no earlier run wrote",
                           test_name, w);
               end
               exp_items.push_back(model_mem[w][ITEM_W*lane +: ITEM_W]);
               a = a + oc.incr;
            end
         end
         a = a + oc.shift;
      end
   endtask

   task automatic execute_run(input string name, input logic pp, input read_cfg_t rc,
                              input gen_cfg_t oc);
      logic [ADDR_W-1:0] base;
      test_name = name;
      base = '0;
      base[ADDR_W-1] = pp && !tb_pp;
      read_addrs.delete();
      if (rc.enabled) begin
         plan_reads(rc.gen, base);
      end
      plan_items(oc, pp, pp && tb_pp);
      tb_pp = pp && !tb_pp;
      cur_ext = rc.ext_addr;
      cur_len = rc.enabled ? int'(rc.length) : 0;
      ack_count = 0;
      item_idx = 0;
      read_off = !rc.enabled;
      @(negedge clk);
      pingpong_i = pp;
      rcfg_i = rc;
      ocfg_i = oc;
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      while (!done_o) begin
         @(negedge clk);
      end
      // settle before the run totals
      repeat (2) @(negedge clk);
      assert (ack_count == cur_len) else begin
         burst_errs++;
         $display("Error %s: acks expected %0d, actual %0d", test_name, cur_len, ack_count);
      end
      assert (exp_items.size() == 0) else begin
         item_errs++;
         $display("%s ended with %0d predicted items never streamed", test_name,
                  exp_items.size());
      end
      read_off = 1'b0;
   endtask

   // wishbone slave with 0 to 3 wait cycles
   always @(negedge clk) begin
      if (rst || wb_i.ack) begin
         wb_i.ack = 1'b0;
      end else if (wb_o.cyc && wb_o.stb) begin
         if (!pending) begin
            pending = 1'b1;
            rng = xorshift32(rng);
            wait_left = int'(rng[1:0]);
         end
         if (wait_left == 0) begin
            wb_i.ack = 1'b1;
            wb_i.dat = mem_word(wb_o.adr);
            pending = 1'b0;
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

   always @(posedge clk) begin
      if (!rst && wb_o.cyc && wb_o.stb && wb_i.ack) begin
         assert (ack_count < cur_len) else begin
            burst_errs++;
            $display("%s got more acks than the burst length", test_name);
         end
         assert (wb_o.adr == cur_ext + BUS_ADDR_W'(4 * ack_count)) else begin
            burst_errs++;
            $display("Error %s: adr expected %h, actual %h", test_name,
                     cur_ext + BUS_ADDR_W'(4 * ack_count), wb_o.adr);
         end
         if (ack_count < read_addrs.size()) begin
            model_mem[read_addrs[ack_count]] = wb_i.dat;
            written[read_addrs[ack_count]] = 1'b1;
         end
         ack_count++;
      end
      if (!rst && read_off) begin
         assert (!wb_o.cyc) else begin
            burst_errs++;
            $display("%s raised cyc with the read side disabled", test_name);
         end
      end
   end

   always @(posedge clk) begin
      if (!rst && item_valid_o) begin
         if (exp_items.size() == 0) begin
            item_errs++;
            $display("%s streamed an item that was not predicted", test_name);
         end else begin
            exp_item = exp_items.pop_front();
            assert (item_o === exp_item) else begin
               item_errs++;
               $display("Error %s: item %0d expected %h, actual %h", test_name, item_idx,
                        exp_item, item_o);
            end
            item_idx++;
         end
      end
   end

   a_we_low: assert property (@(posedge clk) disable iff (rst)
      wb_o.cyc |-> !wb_o.we)
      else begin
         burst_errs++;
         $display("%s drove a bus write", test_name);
      end

   a_cyc_starts_with_stb: assert property (@(posedge clk) disable iff (rst)
      $rose(wb_o.cyc) |-> wb_o.stb)
      else begin
         burst_errs++;
         $display("%s raised cyc without a request", test_name);
      end

   a_cyc_held: assert property (@(posedge clk) disable iff (rst)
      wb_o.cyc && !(wb_o.stb && wb_i.ack && ack_count + 1 == cur_len) |=> wb_o.cyc)
      else begin
         burst_errs++;
         $display("%s dropped cyc before the last ack of the burst", test_name);
      end

   a_done_falls: assert property (@(posedge clk) disable iff (rst)
      run_i |=> !done_o)
      else begin
         ctrl_errs++;
         $display("%s kept done high after run", test_name);
      end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt == MAX_CYCLES) begin
         $display("timeout: run not finished after %0d cycles", MAX_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      rst = 1'b1;
      run_i = 1'b0;
      pingpong_i = 1'b0;
      rcfg_i = '0;
      ocfg_i = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      assert (done_o === 1'b1 && !wb_o.cyc && !wb_o.stb && !item_valid_o) else begin
         ctrl_errs++;
         $display("outputs not idle after reset");
      end

      // strided fill of the lower half without output items
      execute_run("burst_fill", 1'b0,
                  make_read(make_gen(0, 1, 8, 6, 4, 2, 3), 32'h0000_1000, 24, 1'b1),
                  make_gen(0, 0, 1, 0, 1, 0, 0));
      execute_run("lane_output", 1'b0,
                  make_read(make_gen(0, 1, 1, 1, 1, 0, 0), 32'h0, 8, 1'b0),
                  make_gen(1, 3, 9, 7, 2, 11, 2));
      execute_run("pingpong_upper", 1'b1,
                  make_read(make_gen(0, 1, 5, 4, 4, 0, 1), 32'h0000_2000, 16, 1'b1),
                  make_gen(1, 3, 9, 7, 2, 11, 0));
      execute_run("pingpong_lower", 1'b1,
                  make_read(make_gen(0, 1, 5, 4, 4, 0, 0), 32'h0000_3000, 16, 1'b1),
                  make_gen(0, 3, 8, 5, 4, 1, 1));
      // lower half as filled by the previous ping-pong run
      execute_run("pingpong_readback", 1'b1,
                  make_read(make_gen(0, 1, 1, 1, 1, 0, 0), 32'h0, 8, 1'b0),
                  make_gen(2, 5, 6, 4, 3, 1, 0));

      $display("errors: burst %0d, item %0d, control %0d", burst_errs, item_errs, ctrl_errs);
      if (burst_errs + item_errs + ctrl_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== source/vread_top.sv ====
`timescale 1ns/100ps

module vread_top import vread_pkg::*; #(
   parameter int ADDR_W   = vread_pkg::ADDR_W,
   parameter int PERIOD_W = vread_pkg::PERIOD_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              pingpong_i,
   input  read_cfg_t         rcfg_i,
   input  gen_cfg_t          ocfg_i,
   output wb_m2s_t           wb_o,
   input  wb_s2m_t           wb_i,
   output logic [ITEM_W-1:0] item_o,
   output logic              item_valid_o,
   output logic              done_o
);

   ram_wr_t           ram_wr;
   logic              ram_rd_en;
   logic [ADDR_W-1:0] ram_rd_addr;
   bus_word_u         ram_rd_data;

   vread #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W)
   ) u_vread (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .pingpong_i   (pingpong_i),
      .rcfg_i       (rcfg_i),
      .ocfg_i       (ocfg_i),
      .wb_o         (wb_o),
      .wb_i         (wb_i),
      .ram_wr_o     (ram_wr),
      .ram_rd_en_o  (ram_rd_en),
      .ram_rd_addr_o(ram_rd_addr),
      .ram_rd_data_i(ram_rd_data),
      .item_o       (item_o),
      .item_valid_o (item_valid_o),
      .done_o       (done_o)
   );

   buffer_ram_2p #(
      .ADDR_W(ADDR_W)
   ) u_buffer (
      .clk      (clk),
      .wr_i     (ram_wr),
      .rd_en_i  (ram_rd_en),
      .rd_addr_i(ram_rd_addr),
      .rd_data_o(ram_rd_data)
   );

endmodule

// ==== source/vread.sv ====
`timescale 1ns/100ps

module vread import vread_pkg::*; #(
   parameter int ADDR_W   = vread_pkg::ADDR_W,
   parameter int PERIOD_W = vread_pkg::PERIOD_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              pingpong_i,
   input  read_cfg_t         rcfg_i,
   input  gen_cfg_t          ocfg_i,
   output wb_m2s_t           wb_o,
   input  wb_s2m_t           wb_i,
   output ram_wr_t           ram_wr_o,
   output logic              ram_rd_en_o,
   output logic [ADDR_W-1:0] ram_rd_addr_o,
   input  bus_word_u         ram_rd_data_i,
   output logic [ITEM_W-1:0] item_o,
   output logic              item_valid_o,
   output logic              done_o
);

   localparam int CFG_AW = vread_pkg::ADDR_W;
   localparam int SEL_W  = $clog2(LANES);

   logic done_read;
   logic done_output;
   logic pp_state;

   logic                  cyc_q;
   logic                  stb_q;
   logic [BUS_ADDR_W-1:0] adr_q;
   logic [LEN_W-1:0]      ack_cnt;
   logic                  wb_ack;
   logic                  last_ack;
   bus_word_u             wb_word;

   logic              read_run;
   logic              gen_valid;
   logic              gen_ready;
   logic [ADDR_W-1:0] gen_addr;

   logic              out_valid;
   logic              out_done;
   logic [ADDR_W-1:0] out_addr;
   logic [ADDR_W-1:0] read_start;
   logic [ADDR_W-1:0] out_start_in;
   logic [ADDR_W-1:0] out_start;
   gen_cfg_t          rgen_cfg;
   gen_cfg_t          ogen_cfg;

   logic [SEL_W-1:0] sel_q;
   logic             item_valid_q;

   assign read_run = run_i && rcfg_i.enabled;

   // read fills one half, output drains the other
   assign read_start   = {pingpong_i && !pp_state, {(ADDR_W-1){1'b0}}};
   assign out_start_in = ADDR_W'(ocfg_i.start);
   assign out_start    = {pingpong_i && pp_state, out_start_in[ADDR_W-2:0]};

   always_comb begin
      rgen_cfg       = rcfg_i.gen;
      rgen_cfg.start = CFG_AW'(read_start);
      ogen_cfg       = ocfg_i;
      ogen_cfg.start = CFG_AW'(out_start);
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= pingpong_i && !pp_state;
      end
   end

   assign wb_ack   = wb_i.ack && stb_q;
   assign last_ack = wb_ack && (ack_cnt + 1'b1 == rcfg_i.length);
   assign wb_word.word = wb_i.dat;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         ack_cnt <= '0;
      end else if (read_run) begin
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         ack_cnt <= '0;
      end else if (wb_ack) begin
         // stb drops for a cycle after every ack
         stb_q   <= 1'b0;
         ack_cnt <= ack_cnt + 1'b1;
         if (last_ack) begin
            cyc_q <= 1'b0;
         end
      end else if (!stb_q && gen_valid && !done_read) begin
         stb_q <= 1'b1;
         cyc_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (read_run) begin
         adr_q <= rcfg_i.ext_addr;
      end else if (wb_ack) begin
         adr_q <= adr_q + BUS_ADDR_W'(4);
      end
   end

   assign wb_o = '{cyc: cyc_q, stb: stb_q, we: 1'b0, adr: adr_q};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_read   <= 1'b1;
         done_output <= 1'b1;
      end else if (run_i) begin
         done_read   <= !rcfg_i.enabled || (rcfg_i.length == '0);
         done_output <= 1'b0;
      end else begin
         if (last_ack) begin
            done_read <= 1'b1;
         end
         if (out_done) begin
            done_output <= 1'b1;
         end
      end
   end

   assign done_o = done_read && done_output;

   address_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W)
   ) addrgen_read (
      .clk    (clk),
      .rst    (rst),
      .run_i  (read_run),
      .cfg_i  (rgen_cfg),
      .ready_i(gen_ready),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o ()
   );

   memory_writer #(
      .ADDR_W(ADDR_W)
   ) writer (
      .clk         (clk),
      .rst         (rst),
      .gen_valid_i (gen_valid),
      .gen_addr_i  (gen_addr),
      .gen_ready_o (gen_ready),
      .data_valid_i(wb_ack),
      .data_i      (wb_word),
      .wr_o        (ram_wr_o)
   );

   // output never stalls
   address_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W)
   ) addrgen_output (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (ogen_cfg),
      .ready_i(1'b1),
      .valid_o(out_valid),
      .addr_o (out_addr),
      .done_o (out_done)
   );

   // lane address to word address with the half bit kept only in ping-pong
   always_comb begin
      ram_rd_addr_o = {1'b0, out_addr[ADDR_W-2:0]} >> SEL_W;
      ram_rd_addr_o[ADDR_W-1] = pingpong_i && out_addr[ADDR_W-1];
   end

   assign ram_rd_en_o = out_valid;

   always_ff @(posedge clk) begin
      if (out_valid) begin
         sel_q <= out_addr[SEL_W-1:0];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         item_valid_q <= 1'b0;
      end else begin
         item_valid_q <= out_valid;
      end
   end

   assign item_o       = ram_rd_data_i.lane[sel_q];
   assign item_valid_o = item_valid_q;

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb |-> wb_o.cyc);

endmodule

// ==== source/buffer_ram_2p.sv ====
`timescale 1ns/100ps

module buffer_ram_2p import vread_pkg::*; #(
   parameter int ADDR_W = vread_pkg::ADDR_W
) (
   input  logic              clk,
   input  ram_wr_t           wr_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output bus_word_u         rd_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   bus_word_u         mem [DEPTH];
   logic [ADDR_W-1:0] wr_addr;

   assign wr_addr = ADDR_W'(wr_i.addr);

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_addr] <= wr_i.data;
      end
   end

   // one cycle read latency
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== source/memory_writer.sv ====
`timescale 1ns/100ps

module memory_writer import vread_pkg::*; #(
   parameter int ADDR_W = vread_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              gen_valid_i,
   input  logic [ADDR_W-1:0] gen_addr_i,
   output logic              gen_ready_o,
   input  logic              data_valid_i,
   input  bus_word_u         data_i,
   output ram_wr_t           wr_o
);

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   bus_word_u         wr_data;
   logic              accept;

   // one generator address per arriving word
   assign accept      = gen_valid_i && data_valid_i;
   assign gen_ready_o = data_valid_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wr_addr <= gen_addr_i;
         wr_data <= data_i;
      end
   end

   always_comb begin
      wr_o.en   = wr_en;
      wr_o.addr = $bits(wr_o.addr)'(wr_addr);
      wr_o.data = wr_data;
   end

   // request gating in vread keeps the generator ahead of the bus
   a_data_has_addr: assert property (@(posedge clk) disable iff (rst)
      data_valid_i |-> gen_valid_i);

endmodule

// ==== source/address_gen.sv ====
`timescale 1ns/100ps

module address_gen import vread_pkg::*; #(
   parameter int ADDR_W   = vread_pkg::ADDR_W,
   parameter int PERIOD_W = vread_pkg::PERIOD_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  gen_cfg_t          cfg_i,
   input  logic              ready_i,
   output logic              valid_o,
   output logic [ADDR_W-1:0] addr_o,
   output logic              done_o
);

   logic                running;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] pos;
   logic [ADDR_W-1:0]   iter_cnt;
   logic [ADDR_W-1:0]   addr;
   logic [ADDR_W-1:0]   next_addr;

   logic [ADDR_W-1:0]   start;
   logic [ADDR_W-1:0]   incr;
   logic [ADDR_W-1:0]   shift;
   logic [ADDR_W-1:0]   iter;
   logic [PERIOD_W-1:0] per;
   logic [PERIOD_W-1:0] duty;

   logic active;
   logic in_duty;
   logic step;
   logic last_pos;
   logic last_iter;

   assign start = ADDR_W'(cfg_i.start);
   assign incr  = ADDR_W'(cfg_i.incr);
   assign shift = ADDR_W'(cfg_i.shift);
   assign iter  = ADDR_W'(cfg_i.iter);
   assign per   = PERIOD_W'(cfg_i.per);
   assign duty  = PERIOD_W'(cfg_i.duty);

   assign active  = running && (delay_cnt == '0);
   assign in_duty = pos < duty;

   // gap positions move on their own, duty positions wait for ready
   assign step = active && (!in_duty || ready_i);

   // zero period or zero iterations end after one step
   assign last_pos  = ({1'b0, pos} + 1'b1) >= {1'b0, per};
   assign last_iter = ({1'b0, iter_cnt} + 1'b1) >= {1'b0, iter};

   always_comb begin
      next_addr = addr;
      if (in_duty) begin
         next_addr = next_addr + incr;
      end
      if (last_pos) begin
         next_addr = next_addr + shift;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running   <= 1'b0;
         delay_cnt <= '0;
         pos       <= '0;
         iter_cnt  <= '0;
         done_o    <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (run_i) begin
            running   <= 1'b1;
            delay_cnt <= cfg_i.delay;
            pos       <= '0;
            iter_cnt  <= '0;
         end else if (running && delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end else if (step) begin
            if (last_pos) begin
               pos      <= '0;
               iter_cnt <= iter_cnt + 1'b1;
               if (last_iter) begin
                  running <= 1'b0;
                  done_o  <= 1'b1;
               end
            end else begin
               pos <= pos + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         addr <= start;
      end else if (step) begin
         addr <= next_addr;
      end
   end

   assign valid_o = active && in_duty;
   assign addr_o  = addr;

   // a pending address must not move under the consumer
   a_hold_addr: assert property (@(posedge clk) disable iff (rst)
      valid_o && !ready_i && !run_i |=> valid_o && $stable(addr_o));

endmodule

// ==== source/vread_pkg.sv ====
package vread_pkg;

   // buffer address, including the ping-pong half bit
   localparam int ADDR_W     = 10;
   localparam int PERIOD_W   = 8;
   localparam int BUS_DATA_W = 32;
   localparam int BUS_ADDR_W = 32;
   localparam int ITEM_W     = 8;
   localparam int LANES      = BUS_DATA_W / ITEM_W;
   localparam int LEN_W      = 8;
   localparam int DELAY_W    = 7;

   // one loop level of an address generator
   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [ADDR_W-1:0]   incr;
      logic [PERIOD_W-1:0] per;
      logic [PERIOD_W-1:0] duty;
      logic [ADDR_W-1:0]   iter;
      logic [ADDR_W-1:0]   shift;
      logic [DELAY_W-1:0]  delay;
   } gen_cfg_t;

   typedef struct packed {
      gen_cfg_t              gen;
      logic [BUS_ADDR_W-1:0] ext_addr;
      logic [LEN_W-1:0]      length;
      logic                  enabled;
   } read_cfg_t;

   // wishbone classic, read only
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [BUS_ADDR_W-1:0] adr;
   } wb_m2s_t;

   typedef struct packed {
      logic                  ack;
      logic [BUS_DATA_W-1:0] dat;
   } wb_s2m_t;

   // bus side sees the whole word, output side picks a lane
   typedef union packed {
      logic [BUS_DATA_W-1:0]        word;
      logic [LANES-1:0][ITEM_W-1:0] lane;
   } bus_word_u;

   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      bus_word_u         data;
   } ram_wr_t;

endpackage
